// ==== Bender.yml ====
package:
  name: mania_draw

export_include_dirs:
  - .

sources:
  - draw_pkg.sv
  - sprite_pkg.sv
  - lane_decoder.sv
  - score_decoder.sv
  - sprite_fetch.sv
  - draw_top.sv
  - target: test
    files:
      - draw_asserts.sv
      - draw_tb.sv

// ==== draw_asserts.sv ====
// ------------------------------------------------
// sprite fetch assertions
// wishbone read rules and frame control
// ------------------------------------------------
`timescale 1ns/1ps

module draw_asserts (
	input logic                CLK,
	input logic                RESET_L,
	input logic                vga_request,
	input logic                vga_reset,
	input sprite_pkg::wb_req_t sprite_req,
	input sprite_pkg::wb_rsp_t sprite_rsp
);
	import sprite_pkg::*;

	cyc_from_request: assert property (@(posedge CLK) disable iff (!RESET_L)
		$rose(sprite_req.cyc) |-> $past(vga_request))
		else $error("bus cycle started without a request");

	adr_held: assert property (@(posedge CLK) disable iff (!RESET_L)
		sprite_req.stb && !sprite_rsp.ack |=> $stable(sprite_req.adr))
		else $error("adr changed before ack");

	idle_in_reset: assert property (@(posedge CLK) disable iff (!RESET_L)
		vga_reset |-> !sprite_req.cyc)
		else $error("bus cycle while vga_reset is high");

	cyc_drops: assert property (@(posedge CLK) disable iff (!RESET_L)
		sprite_req.cyc && sprite_rsp.ack |=> !sprite_req.cyc)
		else $error("cyc still high after ack");

endmodule

bind sprite_fetch draw_asserts u_asserts (
	.CLK         (CLK),
	.RESET_L     (RESET_L),
	.vga_request (vga_request),
	.vga_reset   (vga_reset),
	.sprite_req  (sprite_req),
	.sprite_rsp  (sprite_rsp)
);

// ==== draw_consts.svh ====
// ------------------------------------------------
// mania_draw layout constants
// screen coordinates, sprite bases and field widths
// ------------------------------------------------
`ifndef DRAW_CONSTS_SVH
`define DRAW_CONSTS_SVH

// field widths
`define PIX_W        10
`define SADDR_W      15 // sprite word address, wraps mod 2^15
`define RGB_W        4
`define WB_DAT_W     16
`define SCORE_W      16 // four bcd nibbles

// lane rows
`define LANE_TOP     200
`define LANE_H       60
`define LANE_COUNT   4
`define KEY_X0       420 // key strip left edge

`define BASE_DOWN_BUTTON 19080
`define BASE_UP_BUTTON   22680

// scoreboard glyphs
`define SIGN_W       24
`define SIGN_H       64
`define DIGIT_H      20
`define DIGIT_GAP    3
`define DIGIT_SIZE   480 // words per digit glyph
`define DIGIT_COUNT  4
`define SCORE_COUNT  5

`define LABEL_Y      453
`define DIGIT_Y0     527

// judgement columns
`define X_PERFECT    396
`define X_GREAT      356
`define X_GOOD       316
`define X_BAD        276
`define X_MISS       236

`define BASE_PERFECT 4800
`define BASE_GREAT   6336
`define BASE_GOOD    7872
`define BASE_BAD     9408
`define BASE_MISS    10944

`endif

// ==== draw_pkg.sv ====
// ------------------------------------------------
// screen-side types: pixel position, score set
// ------------------------------------------------
package draw_pkg;

	`include "draw_consts.svh"

	// requested pixel
	typedef struct packed {
		logic [`PIX_W-1:0] x;
		logic [`PIX_W-1:0] y;
	} pixel_pos_t;

	// bcd judgement counts, perfect in the top field
	typedef struct packed {
		logic [`SCORE_W-1:0] perfect;
		logic [`SCORE_W-1:0] great;
		logic [`SCORE_W-1:0] good;
		logic [`SCORE_W-1:0] bad;
		logic [`SCORE_W-1:0] miss;
	} score_set_t;

endpackage

// ==== draw_tb.sv ====
// ------------------------------------------------
// mania_draw testbench
// random pixels against a layout model, with a
// sprite memory that acks after a random wait
// ------------------------------------------------
`timescale 1ns/1ps
`include "draw_consts.svh"

module draw_tb;
	import draw_pkg::*;
	import sprite_pkg::*;

	localparam int NUM_REQ = 2500;
	localparam int MAX_CYCLES = NUM_REQ * 16; // worst request stays well under 16 cycles
	localparam int ADDR_MOD = 1 << `SADDR_W;
	localparam int COL_X [5] = '{`X_PERFECT, `X_GREAT, `X_GOOD, `X_BAD, `X_MISS};
	localparam int COL_BASE [5] = '{`BASE_PERFECT, `BASE_GREAT, `BASE_GOOD, `BASE_BAD,
		`BASE_MISS};

	logic       CLK;
	logic       RESET_L;
	logic       frame_on;
	logic       vga_request;
	logic       vga_reset;
	logic [3:0] key_down;
	score_set_t scores;
	pixel_pos_t pix;
	rgb_t       rgb;
	wb_req_t    sprite_req;
	wb_rsp_t    sprite_rsp;
	int         cycles = 0;
	int         wait_left;
	logic       pending;

	draw_top dut0 (
		.CLK         (CLK),
		.RESET_L     (RESET_L),
		.frame_on    (frame_on),
		.key_down    (key_down),
		.scores      (scores),
		.pix         (pix),
		.vga_request (vga_request),
		.vga_reset   (vga_reset),
		.rgb         (rgb),
		.sprite_req  (sprite_req),
		.sprite_rsp  (sprite_rsp)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$fatal(1, "cycle limit reached");
		end
	end

	// sprite memory, word = low address bits xor 5a5
	always @(posedge CLK) begin
		if (!RESET_L) begin
			sprite_rsp <= '0;
			pending = 1'b0;
			wait_left = 0;
		end else if (sprite_rsp.ack) begin
			sprite_rsp.ack <= 1'b0;
		end else if (sprite_req.cyc && sprite_req.stb) begin
			if (!pending) begin
				wait_left = $urandom % 4;
				pending = 1'b1;
			end
			if (wait_left == 0) begin
				sprite_rsp.ack <= 1'b1;
				sprite_rsp.dat <= {4'h0, sprite_req.adr[11:0] ^ 12'h5a5};
				pending = 1'b0;
			end else begin
				wait_left = wait_left - 1;
			end
		end
	end

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, expected,
				actual);
			$display("Testbench failed");
			$fatal(1, "value check failed");
		end
	endtask

	function automatic logic [15:0] random_bcd();
		logic [15:0] v;
		for (int k = 0; k < 4; k++)
			v[4*k +: 4] = 4'($urandom % 10);
		return v;
	endfunction

	function automatic score_set_t random_scores();
		score_set_t s;
		s.perfect = random_bcd();
		s.great = random_bcd();
		s.good = random_bcd();
		s.bad = random_bcd();
		s.miss = random_bcd();
		return s;
	endfunction

	// region 0 key strip, 1 scoreboard boxes, else lane left or anywhere
	function automatic pixel_pos_t pick_pixel(int region);
		pixel_pos_t p;
		int col;
		int kind;
		col = $urandom % 5;
		kind = $urandom % 5;
		p.x = `PIX_W'($urandom);
		p.y = `PIX_W'($urandom);
		if (region == 0) begin
			p.x = `PIX_W'(`KEY_X0 + $urandom % 220);
			p.y = `PIX_W'(`LANE_TOP + $urandom % 240);
		end else if (region == 1) begin
			p.x = `PIX_W'(COL_X[col] + $urandom % `SIGN_W);
			if (kind == 0)
				p.y = `PIX_W'(`LABEL_Y + $urandom % `SIGN_H);
			else
				p.y = `PIX_W'(`DIGIT_Y0 + 23 * (kind - 1) + $urandom % `DIGIT_H);
		end else if (kind < 2) begin
			p.x = `PIX_W'($urandom % `KEY_X0);
			p.y = `PIX_W'(`LANE_TOP + $urandom % 240);
		end else if (kind < 4) begin
			p.y = `PIX_W'($urandom % `LANE_TOP);
		end
		return p;
	endfunction

	function automatic int model_addr(pixel_pos_t p, logic [3:0] keys, score_set_t s);
		int x;
		int y;
		int lane;
		int top;
		int nib;
		logic [15:0] cnt [5];
		x = int'(p.x);
		y = int'(p.y);
		cnt = '{s.perfect, s.great, s.good, s.bad, s.miss};
		if (y >= `LANE_TOP && y < `LANE_TOP + `LANE_COUNT * `LANE_H) begin
			lane = (y - `LANE_TOP) / `LANE_H;
			if (x < `KEY_X0)
				return 0;
			top = keys[lane] ? `BASE_DOWN_BUTTON : `BASE_UP_BUTTON;
			return (top + (x - `KEY_X0) * `LANE_H + (y - `LANE_TOP) % `LANE_H) % ADDR_MOD;
		end
		for (int c = 0; c < 5; c++) begin
			if (x >= COL_X[c] && x < COL_X[c] + `SIGN_W) begin
				if (y >= `LABEL_Y && y < `LABEL_Y + `SIGN_H)
					return (COL_BASE[c] + (x - COL_X[c]) * `SIGN_H + y - `LABEL_Y) % ADDR_MOD;
				for (int i = 0; i < 4; i++) begin
					top = `DIGIT_Y0 + i * (`DIGIT_H + `DIGIT_GAP);
					if (y >= top && y < top + `DIGIT_H) begin
						nib = (cnt[c] >> (4 * (3 - i))) & 15;
						return (nib * `DIGIT_SIZE + (x - COL_X[c]) * `DIGIT_H + y - top)
							% ADDR_MOD;
					end
				end
			end
		end
		return 0;
	endfunction

	task automatic pulse_frame();
		@(posedge CLK);
		frame_on <= 1'b1;
		@(posedge CLK);
		frame_on <= 1'b0;
	endtask

	task automatic send_request(pixel_pos_t p, logic [3:0] keys, score_set_t s);
		@(posedge CLK);
		pix <= p;
		key_down <= keys;
		scores <= s;
		vga_request <= 1'b1;
		@(posedge CLK);
		vga_request <= 1'b0;
	endtask

	task automatic await_result(int adr);
		@(negedge CLK);
		check_value("sprite_req.cyc", 1, sprite_req.cyc);
		check_value("sprite_req.stb", 1, sprite_req.stb);
		check_value("sprite_req.adr", adr, sprite_req.adr);
		while (sprite_req.cyc)
			@(negedge CLK);
		check_value("rgb", (adr & 'hfff) ^ 'h5a5, rgb);
	endtask

	task automatic run_batch(int region, int count, bit overlap);
		pixel_pos_t p;
		logic [3:0] keys;
		score_set_t s;
		for (int n = 0; n < count; n++) begin
			p = pick_pixel(region);
			keys = 4'($urandom);
			s = random_scores();
			send_request(p, keys, s);
			if (overlap) begin
				pix <= pick_pixel($urandom % 3); // lands while cyc is high
				vga_request <= 1'b1;
				@(posedge CLK);
				vga_request <= 1'b0;
			end
			await_result(model_addr(p, keys, s));
			if (overlap) begin
				repeat (2) begin
					@(negedge CLK);
					check_value("sprite_req.cyc", 0, sprite_req.cyc);
				end
			end
		end
	endtask

	initial begin
		void'($urandom(32));
		RESET_L = 1'b0;
		frame_on = 1'b0;
		vga_request = 1'b0;
		key_down = '0;
		scores = '0;
		pix = '0;
		sprite_rsp = '0;
		repeat (5) @(posedge CLK);
		RESET_L <= 1'b1;
		@(negedge CLK);
		check_value("vga_reset", 1, vga_reset);
		check_value("sprite_req.cyc", 0, sprite_req.cyc);
		check_value("rgb", 0, rgb);
		pulse_frame();
		@(negedge CLK);
		check_value("vga_reset", 0, vga_reset);

		// black first frame
		for (int n = 0; n < 100; n++) begin
			send_request(pick_pixel($urandom % 3), 4'($urandom), random_scores());
			@(negedge CLK);
			check_value("sprite_req.cyc", 0, sprite_req.cyc);
			check_value("rgb", 0, rgb);
		end
		pulse_frame();

		run_batch(0, 800, 1'b0);
		run_batch(1, 800, 1'b0);
		run_batch(2, 600, 1'b0);
		run_batch($urandom % 3, 200, 1'b1);

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== draw_top.sv ====
// ------------------------------------------------
// mania_draw top
// pixel decoders feeding the sprite fetcher
// ------------------------------------------------
`timescale 1ns/1ps

module draw_top (
	input  logic                  CLK,
	input  logic                  RESET_L,
	input  logic                  frame_on,
	input  logic [3:0]            key_down,
	input  draw_pkg::score_set_t  scores,
	input  draw_pkg::pixel_pos_t  pix,
	input  logic                  vga_request,
	output logic                  vga_reset,
	output sprite_pkg::rgb_t      rgb,
	output sprite_pkg::wb_req_t   sprite_req,
	input  sprite_pkg::wb_rsp_t   sprite_rsp
);
	import sprite_pkg::*;

	sprite_hit_t lane_hit;
	sprite_hit_t score_hit;

	lane_decoder u_lane (
		.pix      (pix),
		.key_down (key_down),
		.lane_hit (lane_hit)
	);

	score_decoder u_score (
		.pix       (pix),
		.scores    (scores),
		.score_hit (score_hit)
	);

	sprite_fetch u_fetch (
		.CLK         (CLK),
		.RESET_L     (RESET_L),
		.frame_on    (frame_on),
		.vga_request (vga_request),
		.lane_hit    (lane_hit),
		.score_hit   (score_hit),
		.vga_reset   (vga_reset),
		.rgb         (rgb),
		.sprite_req  (sprite_req),
		.sprite_rsp  (sprite_rsp)
	);

endmodule

// ==== lane_decoder.sv ====
// ------------------------------------------------
// lane decoder
// maps a lane row pixel to a key button sprite
// ------------------------------------------------
`timescale 1ns/1ps
`include "draw_consts.svh"

module lane_decoder (
	input  draw_pkg::pixel_pos_t    pix,
	input  logic [`LANE_COUNT-1:0]  key_down,
	output sprite_pkg::sprite_hit_t lane_hit
);
	import sprite_pkg::*;

	always_comb begin
		sprite_addr_t base;
		logic [`PIX_W-1:0] top;

		lane_hit = '0;
		base = '0;
		top = '0;
		for (int i = 0; i < `LANE_COUNT; i++) begin
			top = `PIX_W'(`LANE_TOP + i * `LANE_H);
			if (pix.y >= top && pix.y < top + `LANE_H) begin
				lane_hit.hit = 1'b1;
				// left of the strip is note area, fetch word zero
				if (pix.x >= `KEY_X0) begin
					base = key_down[i] ? sprite_addr_t'(`BASE_DOWN_BUTTON)
						: sprite_addr_t'(`BASE_UP_BUTTON);
					// sprite stored column major, 60 words per column
					lane_hit.addr = sprite_addr_t'(base + (pix.x - `KEY_X0) * `LANE_H
						+ (pix.y - top));
				end
			end
		end
	end

endmodule

// ==== mania_draw.f ====
+incdir+.
draw_pkg.sv
sprite_pkg.sv
lane_decoder.sv
score_decoder.sv
sprite_fetch.sv
draw_top.sv
draw_asserts.sv
draw_tb.sv

// ==== score_decoder.sv ====
// ------------------------------------------------
// score decoder
// labels and bcd digits of the five judgements
// ------------------------------------------------
`timescale 1ns/1ps
`include "draw_consts.svh"

module score_decoder (
	input  draw_pkg::pixel_pos_t    pix,
	input  draw_pkg::score_set_t    scores,
	output sprite_pkg::sprite_hit_t score_hit
);
	import sprite_pkg::*;

	// index 4 is perfect, down to 0 for miss
	localparam logic [`PIX_W-1:0] COL_X [`SCORE_COUNT-1:0] = '{
		`X_PERFECT, `X_GREAT, `X_GOOD, `X_BAD, `X_MISS
	};
	localparam sprite_addr_t COL_BASE [`SCORE_COUNT-1:0] = '{
		`BASE_PERFECT, `BASE_GREAT, `BASE_GOOD, `BASE_BAD, `BASE_MISS
	};

	logic [`SCORE_COUNT-1:0][`SCORE_W-1:0] counts;

	assign counts = scores; // same field order as COL_X

	always_comb begin
		logic [`PIX_W-1:0] dx;
		logic [`PIX_W-1:0] row_top;
		logic [3:0] nibble;

		score_hit = '0;
		dx = '0;
		row_top = '0;
		nibble = '0;
		for (int j = 0; j < `SCORE_COUNT; j++) begin
			if (pix.x >= COL_X[j] && pix.x < COL_X[j] + `SIGN_W) begin
				dx = pix.x - COL_X[j];

				// judgement label
				if (pix.y >= `LABEL_Y && pix.y < `LABEL_Y + `SIGN_H) begin
					score_hit.hit = 1'b1;
					score_hit.addr = sprite_addr_t'(COL_BASE[j] + dx * `SIGN_H
						+ (pix.y - `LABEL_Y));
				end

				// digit rows, most significant first
				for (int i = 0; i < `DIGIT_COUNT; i++) begin
					row_top = `PIX_W'(`DIGIT_Y0 + i * (`DIGIT_H + `DIGIT_GAP));
					if (pix.y >= row_top && pix.y < row_top + `DIGIT_H) begin
						nibble = counts[j][(`DIGIT_COUNT - 1 - i) * 4 +: 4];
						score_hit.hit = 1'b1;
						score_hit.addr = sprite_addr_t'(nibble * `DIGIT_SIZE
							+ dx * `DIGIT_H + (pix.y - row_top));
					end
				end
			end
		end
	end

endmodule

// ==== sprite_fetch.sv ====
// ------------------------------------------------
// sprite fetch
// frame control, wishbone sprite read, colour reg
// ------------------------------------------------
`timescale 1ns/1ps
`include "draw_consts.svh"

module sprite_fetch (
	input  logic                    CLK,
	input  logic                    RESET_L,
	input  logic                    frame_on,
	input  logic                    vga_request,
	input  sprite_pkg::sprite_hit_t lane_hit,
	input  sprite_pkg::sprite_hit_t score_hit,
	output logic                    vga_reset,
	output sprite_pkg::rgb_t        rgb,
	output sprite_pkg::wb_req_t     sprite_req,
	input  sprite_pkg::wb_rsp_t     sprite_rsp
);
	import sprite_pkg::*;

	logic         working;
	logic         first_frame;
	logic         cyc;
	logic         accept;
	sprite_addr_t sel_addr;
	sprite_addr_t req_adr;

	// first pulse starts the display, second ends the black frame
	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			working <= 1'b0;
			first_frame <= 1'b1;
		end else if (frame_on) begin
			if (!working)
				working <= 1'b1;
			else
				first_frame <= 1'b0;
		end
	end

	assign vga_reset = !working;

	assign accept = vga_request && !cyc; // busy bus drops the request

	// lane rows win over the scoreboard
	always_comb begin
		if (lane_hit.hit)
			sel_addr = lane_hit.addr;
		else if (score_hit.hit)
			sel_addr = score_hit.addr;
		else
			sel_addr = '0;
	end

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			cyc <= 1'b0;
			rgb <= '0;
		end else if (cyc) begin
			if (sprite_rsp.ack) begin
				cyc <= 1'b0;
				rgb <= rgb_t'(sprite_rsp.dat[3*`RGB_W-1:0]);
			end
		end else if (accept) begin
			if (first_frame)
				rgb <= '0; // black, no bus cycle
			else
				cyc <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept && !first_frame)
			req_adr <= sel_addr;
	end

	// single outstanding read, stb follows cyc
	assign sprite_req.cyc = cyc;
	assign sprite_req.stb = cyc;
	assign sprite_req.adr = req_adr;

endmodule

// ==== sprite_pkg.sv ====
// ------------------------------------------------
// sprite-side types: address, hit, colour and
// the wishbone read request and response
// ------------------------------------------------
package sprite_pkg;

	`include "draw_consts.svh"

	typedef logic [`SADDR_W-1:0] sprite_addr_t;

	typedef struct packed {
		logic         hit;
		sprite_addr_t addr;
	} sprite_hit_t;

	// r sits in the low nibble, same as the memory word
	typedef struct packed {
		logic [`RGB_W-1:0] b;
		logic [`RGB_W-1:0] g;
		logic [`RGB_W-1:0] r;
	} rgb_t;

	typedef struct packed {
		logic         cyc;
		logic         stb;
		sprite_addr_t adr;
	} wb_req_t; // read only

	typedef struct packed {
		logic                 ack;
		logic [`WB_DAT_W-1:0] dat;
	} wb_rsp_t;

endpackage
